/* logic/exec_pkg.sv */
`default_nettype none

// shared types and constants for the scalar execute stage
package exec_pkg;

    // one data word, used for operands, results and branch targets
    typedef logic [31:0] word_t;

    // operation code as issued by the dispatcher
    typedef logic [3:0] alu_op_t;

    // arithmetic and logic operations
    localparam alu_op_t OP_ADD    = 4'd0;
    localparam alu_op_t OP_SUB    = 4'd1;
    localparam alu_op_t OP_AND    = 4'd2;
    localparam alu_op_t OP_OR     = 4'd3;
    localparam alu_op_t OP_XOR    = 4'd4;
    localparam alu_op_t OP_SLL    = 4'd5;
    localparam alu_op_t OP_SRL    = 4'd6;
    localparam alu_op_t OP_SLT    = 4'd7;

    // conditional branches resolve to pc + 4 or pc + a
    localparam alu_op_t OP_BEQ    = 4'd8;
    localparam alu_op_t OP_BNE    = 4'd9;
    localparam alu_op_t OP_BLT    = 4'd10;

    // thread mask write, an empty mask flushes the warp
    localparam alu_op_t OP_TMC    = 4'd11;

    // environment calls, from warp 0 they stop the simulation
    localparam alu_op_t OP_EBREAK = 4'd12;
    localparam alu_op_t OP_ECALL  = 4'd13;

    // codes 14 and 15 are unused and never issued

    // defaults for the top level parameters
    localparam int DEF_NUM_WARPS  = 4;
    localparam int DEF_FIFO_DEPTH = 8;

endpackage

`default_nettype wire

/* logic/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
    parameter int NUM_WARPS = exec_pkg::DEF_NUM_WARPS,
    localparam int WARP_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire                   clk,
    input  wire                   rst_n,

    input  wire                   dispatch_valid,
    input  wire [WARP_W-1:0]      dispatch_warp,
    input  wire exec_pkg::alu_op_t dispatch_op,
    input  wire exec_pkg::word_t  dispatch_a,
    input  wire exec_pkg::word_t  dispatch_b,
    input  wire exec_pkg::word_t  dispatch_pc,

    output logic                  res_valid,
    output logic [WARP_W-1:0]     res_warp,
    output exec_pkg::word_t       res_data,
    output logic                  res_taken,

    output logic [NUM_WARPS-1:0]  branch_flush,
    output logic                  sim_ebreak
);
    import exec_pkg::*;

    word_t                result_c;
    logic                 taken_c;
    logic                 halt_c;
    logic [NUM_WARPS-1:0] flush_c;
    word_t                pc_next;
    word_t                pc_target;

    // both branch outcomes are formed up front, the op picks one
    assign pc_next   = dispatch_pc + 32'd4;
    assign pc_target = dispatch_pc + dispatch_a;

    always_comb begin
        result_c = '0;
        taken_c  = 1'b0;
        case (dispatch_op)
            OP_ADD: result_c = dispatch_a + dispatch_b;
            OP_SUB: result_c = dispatch_a - dispatch_b;
            OP_AND: result_c = dispatch_a & dispatch_b;
            OP_OR:  result_c = dispatch_a | dispatch_b;
            OP_XOR: result_c = dispatch_a ^ dispatch_b;
            OP_SLL: result_c = dispatch_a << dispatch_b[4:0];
            OP_SRL: result_c = dispatch_a >> dispatch_b[4:0];
            OP_SLT: result_c = word_t'($signed(dispatch_a) < $signed(dispatch_b));
            OP_BEQ: begin
                taken_c  = (dispatch_a == dispatch_b);
                result_c = taken_c ? pc_target : pc_next;
            end
            OP_BNE: begin
                taken_c  = (dispatch_a != dispatch_b);
                result_c = taken_c ? pc_target : pc_next;
            end
            OP_BLT: begin
                taken_c  = ($signed(dispatch_a) < $signed(dispatch_b));
                result_c = taken_c ? pc_target : pc_next;
            end
            OP_TMC: begin
                // the new mask is committed as the result
                result_c = dispatch_b;
                taken_c  = (dispatch_b == '0);
            end
            OP_EBREAK, OP_ECALL: result_c = dispatch_pc;
            default: result_c = '0;
        endcase
    end

    // only warp 0 may end the simulation
    assign halt_c = ((dispatch_op == OP_EBREAK) || (dispatch_op == OP_ECALL))
                 && (dispatch_warp == '0);

    // a taken branch or an empty thread mask flushes the issuing warp only
    always_comb begin
        flush_c = '0;
        if (taken_c) begin
            flush_c[dispatch_warp] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid    <= 1'b0;
            branch_flush <= '0;
            sim_ebreak   <= 1'b0;
        end else begin
            res_valid    <= dispatch_valid;
            branch_flush <= dispatch_valid ? flush_c : '0;
            sim_ebreak   <= dispatch_valid && halt_c;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            res_warp  <= dispatch_warp;
            res_data  <= result_c;
            res_taken <= taken_c;
        end
    end

    // the dispatcher never issues one of the two spare op codes
    a_op_defined : assert property (
        @(posedge clk) disable iff (!rst_n)
        dispatch_valid |-> (dispatch_op <= OP_ECALL)
    ) else $error("alu_unit: undefined op code %0d dispatched", dispatch_op);

endmodule

`default_nettype wire

/* logic/commit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_fifo #(
    parameter int NUM_WARPS  = exec_pkg::DEF_NUM_WARPS,
    parameter int FIFO_DEPTH = exec_pkg::DEF_FIFO_DEPTH,
    localparam int WARP_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire                  res_valid,
    input  wire [WARP_W-1:0]     res_warp,
    input  wire exec_pkg::word_t res_data,
    input  wire                  res_taken,

    input  wire                  fifo_pop,
    output logic                 fifo_empty,
    output logic [WARP_W-1:0]    head_warp,
    output exec_pkg::word_t      head_data,
    output logic                 head_taken,

    output logic                 dispatch_room
);
    import exec_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [WARP_W-1:0]     warp_mem [FIFO_DEPTH];
    word_t                 data_mem [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0] taken_mem;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // pointers wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (res_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (fifo_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({res_valid, fifo_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            warp_mem[wr_ptr]  <= res_warp;
            data_mem[wr_ptr]  <= res_data;
            taken_mem[wr_ptr] <= res_taken;
        end
    end

    assign fifo_empty = (count == '0);
    assign head_warp  = warp_mem[rd_ptr];
    assign head_data  = data_mem[rd_ptr];
    assign head_taken = taken_mem[rd_ptr];

    // two free slots, one for the result in flight and one for a new dispatch
    assign dispatch_room = (count <= CNT_W'(FIFO_DEPTH - 2));

    // the room rule upstream must keep the buffer from overflowing
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid && !fifo_pop |-> (count != CNT_W'(FIFO_DEPTH))
    ) else $error("commit_fifo: push while full");

    a_no_underflow : assert property (
        @(posedge clk) disable iff (!rst_n)
        fifo_pop |-> !fifo_empty
    ) else $error("commit_fifo: pop while empty");

endmodule

`default_nettype wire

/* logic/commit_drain.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_drain #(
    parameter int NUM_WARPS = exec_pkg::DEF_NUM_WARPS,
    localparam int WARP_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire                  commit_stall,

    input  wire                  fifo_empty,
    input  wire [WARP_W-1:0]     head_warp,
    input  wire exec_pkg::word_t head_data,
    input  wire                  head_taken,
    output logic                 fifo_pop,

    output logic                 commit_valid,
    output logic [WARP_W-1:0]    commit_warp,
    output exec_pkg::word_t      commit_data,
    output logic                 commit_taken
);
    import exec_pkg::*;

    // the output register frees up when empty or when writeback takes it now
    assign fifo_pop = !fifo_empty && (!commit_valid || !commit_stall);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= fifo_pop || (commit_valid && commit_stall);
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            commit_warp  <= head_warp;
            commit_data  <= head_data;
            commit_taken <= head_taken;
        end
    end

    // writeback sees the same entry until it lifts the stall
    a_hold_under_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_valid && commit_stall |=> commit_valid && $stable(commit_data)
    ) else $error("commit_drain: commit changed while stalled");

endmodule

`default_nettype wire

/* logic/execute_scalar.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_scalar #(
    parameter int NUM_WARPS  = exec_pkg::DEF_NUM_WARPS,
    parameter int FIFO_DEPTH = exec_pkg::DEF_FIFO_DEPTH,
    localparam int WARP_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire                    clk,
    input  wire                    rst_n,

    // dispatch, one instruction per strobe
    input  wire                    dispatch_valid,
    input  wire [WARP_W-1:0]       dispatch_warp,
    input  wire exec_pkg::alu_op_t dispatch_op,
    input  wire exec_pkg::word_t   dispatch_a,
    input  wire exec_pkg::word_t   dispatch_b,
    input  wire exec_pkg::word_t   dispatch_pc,
    output wire                    dispatch_room,

    // commit toward writeback
    input  wire                    commit_stall,
    output wire                    commit_valid,
    output wire [WARP_W-1:0]       commit_warp,
    output exec_pkg::word_t        commit_data,
    output wire                    commit_taken,

    output wire [NUM_WARPS-1:0]    branch_flush,
    output wire                    sim_ebreak
);
    import exec_pkg::*;

    wire                res_valid;
    wire [WARP_W-1:0]   res_warp;
    wire word_t         res_data;
    wire                res_taken;

    wire                fifo_pop;
    wire                fifo_empty;
    wire [WARP_W-1:0]   head_warp;
    wire word_t         head_data;
    wire                head_taken;

    alu_unit #(
        .NUM_WARPS      (NUM_WARPS)
    ) u_alu (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_warp  (dispatch_warp),
        .dispatch_op    (dispatch_op),
        .dispatch_a     (dispatch_a),
        .dispatch_b     (dispatch_b),
        .dispatch_pc    (dispatch_pc),
        .res_valid      (res_valid),
        .res_warp       (res_warp),
        .res_data       (res_data),
        .res_taken      (res_taken),
        .branch_flush   (branch_flush),
        .sim_ebreak     (sim_ebreak)
    );

    commit_fifo #(
        .NUM_WARPS      (NUM_WARPS),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) u_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .res_valid      (res_valid),
        .res_warp       (res_warp),
        .res_data       (res_data),
        .res_taken      (res_taken),
        .fifo_pop       (fifo_pop),
        .fifo_empty     (fifo_empty),
        .head_warp      (head_warp),
        .head_data      (head_data),
        .head_taken     (head_taken),
        .dispatch_room  (dispatch_room)
    );

    commit_drain #(
        .NUM_WARPS      (NUM_WARPS)
    ) u_drain (
        .clk            (clk),
        .rst_n          (rst_n),
        .commit_stall   (commit_stall),
        .fifo_empty     (fifo_empty),
        .head_warp      (head_warp),
        .head_data      (head_data),
        .head_taken     (head_taken),
        .fifo_pop       (fifo_pop),
        .commit_valid   (commit_valid),
        .commit_warp    (commit_warp),
        .commit_data    (commit_data),
        .commit_taken   (commit_taken)
    );

endmodule

`default_nettype wire

/* verif/tb_execute_scalar.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_execute_scalar;
    import exec_pkg::*;

    localparam int NUM_WARPS  = DEF_NUM_WARPS;
    localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
    localparam int WARP_W     = $clog2(NUM_WARPS);

    logic                clk;
    logic                rst_n;
    logic                dispatch_valid;
    logic [WARP_W-1:0]   dispatch_warp;
    alu_op_t             dispatch_op;
    word_t               dispatch_a;
    word_t               dispatch_b;
    word_t               dispatch_pc;
    logic                commit_stall;
    wire                 dispatch_room;
    wire                 commit_valid;
    wire [WARP_W-1:0]    commit_warp;
    wire word_t          commit_data;
    wire                 commit_taken;
    wire [NUM_WARPS-1:0] branch_flush;
    wire                 sim_ebreak;

    // vectors as read from the file, then the vector index and dispatch cycle of each commit
    alu_op_t           vec_op[$];
    logic [WARP_W-1:0] vec_warp[$];
    word_t             vec_a[$];
    word_t             vec_b[$];
    word_t             vec_pc[$];
    int                vec_mode[$];
    int                exp_vec[$];
    int                exp_cycle[$];

    int                   value_errors;
    int                   other_errors;
    int                   commits;
    int                   cycle;
    int                   next_vec;
    int                   last_vec;
    int                   fifo_level;
    logic                 exp_room;
    logic [31:0]          lfsr;
    logic                 stall_mode;
    logic                 stall_seen;
    logic                 held_valid;
    word_t                held_data;
    logic [NUM_WARPS-1:0] exp_flush;
    logic                 exp_ebreak;

    execute_scalar #(
        .NUM_WARPS  (NUM_WARPS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 where the new bit enters at bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // expected {taken, result} of vector i
    function automatic logic [32:0] expected_result(input int i);
        word_t a;
        word_t b;
        logic  taken;
        a = vec_a[i];
        b = vec_b[i];
        taken = 1'b0;
        case (vec_op[i])
            OP_ADD: return {1'b0, a + b};
            OP_SUB: return {1'b0, a - b};
            OP_AND: return {1'b0, a & b};
            OP_OR:  return {1'b0, a | b};
            OP_XOR: return {1'b0, a ^ b};
            OP_SLL: return {1'b0, a << b[4:0]};
            OP_SRL: return {1'b0, a >> b[4:0]};
            OP_SLT: return {32'b0, $signed(a) < $signed(b)};
            OP_BEQ: taken = (a == b);
            OP_BNE: taken = (a != b);
            OP_BLT: taken = ($signed(a) < $signed(b));
            OP_TMC: return {b == 32'h0, b};
            OP_EBREAK, OP_ECALL: return {1'b0, vec_pc[i]};
            default: return '0;
        endcase
        // only branches get here
        return {taken, taken ? vec_pc[i] + a : vec_pc[i] + 32'd4};
    endfunction

    task automatic report_mismatch(input string name, input int i,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("error %s vector %0d: expected %h, actual %h", name, i, expected, actual);
        value_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("failure: %s", what);
        other_errors++;
    endtask

    task automatic load_vectors();
        int                fd;
        string             line;
        alu_op_t           op;
        logic [WARP_W-1:0] warp;
        word_t             a;
        word_t             b;
        word_t             pc;
        int                mode;
        fd = $fopen("verif/exec_vectors.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open verif/exec_vectors.txt");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.getc(0) != "#" &&
                $sscanf(line, "%h %h %h %h %h %h", op, warp, a, b, pc, mode) == 6) begin
                vec_op.push_back(op);
                vec_warp.push_back(warp);
                vec_a.push_back(a);
                vec_b.push_back(b);
                vec_pc.push_back(pc);
                vec_mode.push_back(mode);
            end
        end
        $fclose(fd);
    endtask

    // compare the commit that writeback takes at the coming edge
    task automatic check_commit();
        int          i;
        int          latency;
        logic [32:0] expected;
        if (exp_vec.size() == 0) begin
            report_failure("commit_valid high with no instruction outstanding");
            return;
        end
        i = exp_vec.pop_front();
        latency = cycle - exp_cycle.pop_front();
        expected = expected_result(i);
        commits++;
        if (commit_data !== expected[31:0])
            report_mismatch("commit_data", i, expected[31:0], commit_data);
        if (commit_taken !== expected[32])
            report_mismatch("commit_taken", i, 32'(expected[32]), 32'(commit_taken));
        if (commit_warp !== vec_warp[i])
            report_mismatch("commit_warp", i, 32'(vec_warp[i]), 32'(commit_warp));
        // until writeback first stalls the path is a fixed 3 cycles deep
        if (!stall_seen && latency != 3)
            report_mismatch("commit_latency", i, 32'd3, latency);
    endtask

    task automatic drive_dispatch(input int i);
        logic [32:0] expected;
        expected = expected_result(i);
        dispatch_valid = 1'b1;
        dispatch_warp  = vec_warp[i];
        dispatch_op    = vec_op[i];
        dispatch_a     = vec_a[i];
        dispatch_b     = vec_b[i];
        dispatch_pc    = vec_pc[i];
        stall_mode     = (vec_mode[i] != 0);
        exp_vec.push_back(i);
        exp_cycle.push_back(cycle);
        // flush and ebreak pulse in the cycle after the accepting edge
        exp_flush = '0;
        if (expected[32])
            exp_flush[vec_warp[i]] = 1'b1;
        exp_ebreak = (vec_op[i] == OP_EBREAK || vec_op[i] == OP_ECALL) && vec_warp[i] == '0;
        last_vec = i;
    endtask

    initial begin
        dispatch_valid = 1'b0;
        dispatch_warp  = '0;
        dispatch_op    = OP_ADD;
        dispatch_a     = '0;
        dispatch_b     = '0;
        dispatch_pc    = '0;
        commit_stall   = 1'b0;
        rst_n          = 1'b0;
        value_errors   = 0;
        other_errors   = 0;
        commits        = 0;
        cycle          = 0;
        next_vec       = 0;
        last_vec       = -1;
        lfsr           = 32'h02d3_602d;
        stall_mode     = 1'b0;
        stall_seen     = 1'b0;
        held_valid     = 1'b0;
        held_data      = '0;
        exp_flush      = '0;
        exp_ebreak     = 1'b0;
        load_vectors();
        if (vec_op.size() == 0)
            report_failure("no vectors were loaded");
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        while ((next_vec < vec_op.size() || exp_vec.size() > 0)
               && cycle < 10 * vec_op.size() + 100) begin
            @(posedge clk);
            #1;
            cycle++;
            if (branch_flush !== exp_flush)
                report_mismatch("branch_flush", last_vec, 32'(exp_flush), 32'(branch_flush));
            if (sim_ebreak !== exp_ebreak)
                report_mismatch("sim_ebreak", last_vec, 32'(exp_ebreak), 32'(sim_ebreak));
            exp_flush  = '0;
            exp_ebreak = 1'b0;
            last_vec   = -1;
            // an entry held under stall must come back unchanged
            if (held_valid && !commit_valid)
                report_failure("commit_valid dropped while writeback was stalled");
            if (held_valid && commit_data !== held_data)
                report_mismatch("commit_hold", exp_vec.size() > 0 ? exp_vec[0] : -1,
                                held_data, commit_data);
            // outstanding entries not held in the ALU or the commit register sit in the buffer
            fifo_level = exp_vec.size() - int'(commit_valid) - int'(dispatch_valid);
            exp_room   = (FIFO_DEPTH - fifo_level) >= 2;
            if (dispatch_room !== exp_room)
                report_mismatch("dispatch_room", next_vec, 32'(exp_room), 32'(dispatch_room));
            commit_stall = 1'b0;
            if (stall_mode) begin
                lfsr = lfsr_next(lfsr);
                commit_stall = lfsr[0];
                stall_seen = stall_seen | lfsr[0];
            end
            if (commit_valid && !commit_stall)
                check_commit();
            held_valid = commit_valid && commit_stall;
            held_data  = commit_data;
            dispatch_valid = 1'b0;
            if (next_vec < vec_op.size() && dispatch_room) begin
                drive_dispatch(next_vec);
                next_vec++;
            end
        end

        dispatch_valid = 1'b0;
        commit_stall   = 1'b0;
        if (exp_vec.size() > 0 || next_vec < vec_op.size()) begin
            report_failure($sformatf("timeout after %0d cycles, %0d commits still outstanding",
                                     cycle, exp_vec.size()));
        end else begin
            // with nothing left in flight the outputs stay quiet
            repeat (4) begin
                @(posedge clk);
                #1;
                if (commit_valid || branch_flush != '0 || sim_ebreak)
                    report_failure("commit or pulse output active with nothing dispatched");
            end
        end
        $display("%0d commits checked, %0d value errors, %0d other errors",
                 commits, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/exec_vectors.txt */
# op warp a b pc stall, all hex, one instruction per line
# stall 0 leaves writeback free, stall 1 stalls it on LFSR bits
# arithmetic and logic on every warp
0 0 00000005 00000007 00001000 0
1 1 00000010 00000020 00001004 0
2 2 f0f0f0f0 0ff00ff0 00001008 0
3 3 12340000 00005678 0000100c 0
4 0 aaaaaaaa 5555ffff 00001010 0
5 1 00000001 0000003f 00001014 0
6 2 80000000 00000024 00001018 0
7 3 ffffffff 00000001 0000101c 0
7 0 00000001 ffffffff 00001020 0
# branches, taken and not taken
8 1 00000040 00000040 00002000 0
8 2 00000040 00000041 00002010 0
9 3 00000080 00000081 00002020 0
9 0 00000080 00000080 00002030 0
a 1 fffffff0 00000003 00002040 0
a 2 00000003 fffffff0 00002050 0
# thread mask writes and environment calls
b 3 00000000 00000000 00003000 0
b 0 00000000 0000000f 00003004 0
c 0 00000000 00000000 00003008 0
c 2 00000000 00000000 0000300c 0
d 0 00000000 00000000 00003010 0
d 3 00000000 00000000 00003014 0
# the same mix with writeback stalling at random
0 1 7fffffff 00000001 00004000 1
8 3 00000010 00000010 00004004 1
1 2 00000000 00000001 00004008 1
b 1 00000000 00000000 0000400c 1
6 0 deadbeef 00000008 00004010 1
a 0 80000000 7fffffff 00004014 1
5 3 0000ffff 00000010 00004018 1
2 1 cafef00d 0000ffff 0000401c 1
9 2 00000001 00000001 00004020 1
c 0 00000000 00000000 00004024 1
3 0 0f0f0000 000000f0 00004028 1
7 2 80000000 00000001 0000402c 1
4 3 ffff0000 ff00ff00 00004030 1
d 1 00000000 00000000 00004034 1
0 2 00000100 00000200 00004038 1
b 3 00000000 00000001 0000403c 1

/* all.f */
logic/exec_pkg.sv
logic/alu_unit.sv
logic/commit_fifo.sv
logic/commit_drain.sv
logic/execute_scalar.sv
verif/tb_execute_scalar.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the execute stage testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
    --top-module tb_execute_scalar -o tb_execute_scalar > build.log 2>&1 \
    && ./obj_dir/tb_execute_scalar > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete" >> sim.log; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
